/* rtl/soc_pkg.sv */
/*
 * Shared types, address map and register offsets for the SoC.
 * Single Wishbone classic master, no err/rty/cti/bte/lock.
 * Region field is adr[31:17]; all slaves are 32-bit word addressed.
 */
`default_nettype none

package soc_pkg;

	// --------------------
	// Vector types
	// --------------------
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  sel_t;
	// Active low, bit 0 is segment a, bit 6 is segment g
	typedef logic [6:0]  seg_t;
	// Active low digit enables
	typedef logic [3:0]  an_t;
	// Bit 0 timer, bit 1 GPIO
	typedef logic [1:0]  irq_vec_t;
	// Switches in 11..4, buttons in 3..0
	typedef logic [11:0] gpio_in_t;

	// --------------------
	// Bus structs
	// --------------------
	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		addr_t adr;
		data_t dat;
		sel_t  sel;
	} wb_req_t;

	typedef struct packed {
		data_t dat;
		logic  ack;
	} wb_rsp_t;

	// Decoded slave region
	typedef enum logic [1:0] {
		SLV_BRAM,
		SLV_TIMER,
		SLV_GPIO,
		SLV_NONE
	} slave_e;

	// --------------------
	// Address map
	// --------------------
	localparam int REGION_MSB = 31;
	localparam int REGION_LSB = 17;

	localparam logic [REGION_MSB:REGION_LSB] BRAM_REGION  = 15'h0000;
	// 0xE002_0000
	localparam logic [REGION_MSB:REGION_LSB] TIMER_REGION = 15'h7001;
	// 0xE004_0000
	localparam logic [REGION_MSB:REGION_LSB] GPIO_REGION  = 15'h7002;

	// RAM depth in words, 4 KB
	localparam int BRAM_AW = 10;

	// Timer word offsets, adr[3:2]
	localparam logic [1:0] TMR_CTRL    = 2'd0;
	localparam logic [1:0] TMR_COMPARE = 2'd1;
	localparam logic [1:0] TMR_COUNTER = 2'd2;

	// Timer CTRL bits
	localparam int CTRL_EN  = 0;
	localparam int CTRL_AR  = 1;
	localparam int CTRL_IRQ = 2;

	// GPIO word offsets, adr[3:2]
	localparam logic [1:0] GPIO_IN     = 2'd0;
	localparam logic [1:0] GPIO_OUT    = 2'd1;
	localparam logic [1:0] GPIO_CHANGE = 2'd2;

	// Digit dwell is 2**SCAN_DIV_W cycles
	localparam int SCAN_DIV_W = 4;

endpackage

`default_nettype wire

/* rtl/wb_decoder.sv */
/*
 * Single-master Wishbone address decoder and read mux.
 * Only stb is gated per slave; other request fields fan out to all.
 * Unmapped accesses ack after one cycle, read as zero, drop writes.
 */
`timescale 1ns/10ps
`default_nettype none

module wb_decoder
	import soc_pkg::*;
(
	input  logic    clk_i,
	input  logic    rst_i,
	// Master side
	input  wb_req_t m_req_i,
	output wb_rsp_t m_rsp_o,
	// Slave requests
	output wb_req_t bram_req_o,
	output wb_req_t tmr_req_o,
	output wb_req_t gpio_req_o,
	// Slave responses
	input  wb_rsp_t bram_rsp_i,
	input  wb_rsp_t tmr_rsp_i,
	input  wb_rsp_t gpio_rsp_i
);

	slave_e                       slv;
	logic [REGION_MSB:REGION_LSB] region;
	logic                         none_ack;

	assign region = m_req_i.adr[REGION_MSB:REGION_LSB];

	// --------------------
	// Region decode
	// --------------------
	always_comb begin
		case (region)
			BRAM_REGION:  slv = SLV_BRAM;
			TIMER_REGION: slv = SLV_TIMER;
			GPIO_REGION:  slv = SLV_GPIO;
			default:      slv = SLV_NONE;
		endcase
	end

	// Copy request, strobe only the selected slave
	always_comb begin
		bram_req_o     = m_req_i;
		tmr_req_o      = m_req_i;
		gpio_req_o     = m_req_i;
		bram_req_o.stb = m_req_i.stb & (slv == SLV_BRAM);
		tmr_req_o.stb  = m_req_i.stb & (slv == SLV_TIMER);
		gpio_req_o.stb = m_req_i.stb & (slv == SLV_GPIO);
	end

	// --------------------
	// Unmapped region ack
	// --------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			none_ack <= 1'b0;
		end else begin
			// Single-cycle pulse, same as a real slave
			none_ack <= m_req_i.cyc & m_req_i.stb & (slv == SLV_NONE) & ~none_ack;
		end
	end

	// Response from the slave named by the current request
	always_comb begin
		case (slv)
			SLV_BRAM:  m_rsp_o = bram_rsp_i;
			SLV_TIMER: m_rsp_o = tmr_rsp_i;
			SLV_GPIO:  m_rsp_o = gpio_rsp_i;
			default: begin
				m_rsp_o.dat = '0;
				m_rsp_o.ack = none_ack;
			end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/wb_bram.sv */
/*
 * Block RAM slave, 2**BRAM_AW words, aliased over its whole region.
 * Byte-lane writes from sel; read data registered to line up with ack.
 * Contents are undefined after power-up.
 */
`timescale 1ns/10ps
`default_nettype none

module wb_bram
	import soc_pkg::*;
(
	input  logic    clk_i,
	input  logic    rst_i,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	data_t              mem [0:(2**BRAM_AW)-1];
	logic [BRAM_AW-1:0] idx;
	logic               access;
	logic               ack;
	data_t              rdata;

	// Word index, byte offset dropped
	assign idx    = req_i.adr[BRAM_AW+1:2];
	assign access = req_i.cyc & req_i.stb & ~ack;

	// Ack pulse
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack <= 1'b0;
		end else begin
			ack <= access;
		end
	end

	// --------------------
	// Storage
	// --------------------
	always_ff @(posedge clk_i) begin
		if (access) begin
			rdata <= mem[idx];
			if (req_i.we) begin
				for (int i = 0; i < 4; i++) begin
					if (req_i.sel[i]) begin
						mem[idx][8*i +: 8] <= req_i.dat[8*i +: 8];
					end
				end
			end
		end
	end

	assign rsp_o.dat = rdata;
	assign rsp_o.ack = ack;

endmodule

`default_nettype wire

/* rtl/wb_timer.sv */
/*
 * 32-bit timer counting clock cycles while EN is set.
 * Match sets a sticky flag; AR restarts at 0, else EN clears and it holds.
 * Registers take whole words, sel is not looked at.
 */
`timescale 1ns/10ps
`default_nettype none

module wb_timer
	import soc_pkg::*;
(
	input  logic    clk_i,
	input  logic    rst_i,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o,
	output logic    irq_o
);

	logic       access;
	logic       wr;
	logic       ack;
	logic [1:0] reg_sel;
	data_t      rdata;
	data_t      rdata_q;
	data_t      compare;
	data_t      counter;
	logic       ctrl_en;
	logic       ctrl_ar;
	logic       irq_flag;
	logic       hit;
	logic       irq_clr;

	assign access  = req_i.cyc & req_i.stb & ~ack;
	assign wr      = access & req_i.we;
	assign reg_sel = req_i.adr[3:2];
	// Match only counts while running
	assign hit     = ctrl_en & (counter == compare);
	// Write 1 to CTRL.IRQ clears the flag
	assign irq_clr = wr & (reg_sel == TMR_CTRL) & req_i.dat[CTRL_IRQ];

	// --------------------
	// Counter and control
	// --------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ctrl_en <= 1'b0;
			ctrl_ar <= 1'b0;
			compare <= '0;
			counter <= '0;
		end else begin
			if (hit) begin
				if (ctrl_ar) begin
					counter <= '0;
				end else begin
					ctrl_en <= 1'b0;
				end
			end else if (ctrl_en) begin
				counter <= counter + 1'b1;
			end
			// Bus write overrides the count step
			if (wr) begin
				case (reg_sel)
					TMR_CTRL: begin
						ctrl_en <= req_i.dat[CTRL_EN];
						ctrl_ar <= req_i.dat[CTRL_AR];
					end
					TMR_COMPARE: compare <= req_i.dat;
					TMR_COUNTER: counter <= req_i.dat;
					default: ;
				endcase
			end
		end
	end

	// Sticky flag, a new match beats a clear
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			irq_flag <= 1'b0;
		end else if (hit) begin
			irq_flag <= 1'b1;
		end else if (irq_clr) begin
			irq_flag <= 1'b0;
		end
	end

	// --------------------
	// Read path
	// --------------------
	always_comb begin
		rdata = '0;
		case (reg_sel)
			TMR_CTRL: begin
				rdata[CTRL_EN]  = ctrl_en;
				rdata[CTRL_AR]  = ctrl_ar;
				rdata[CTRL_IRQ] = irq_flag;
			end
			TMR_COMPARE: rdata = compare;
			TMR_COUNTER: rdata = counter;
			default: ;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack <= 1'b0;
		end else begin
			ack <= access;
		end
	end

	always_ff @(posedge clk_i) begin
		if (access) begin
			rdata_q <= rdata;
		end
	end

	assign rsp_o.dat = rdata_q;
	assign rsp_o.ack = ack;
	assign irq_o     = irq_flag;

endmodule

`default_nettype wire

/* rtl/wb_gpio.sv */
/*
 * GPIO with byte-writable OUT and 12 synchronized inputs.
 * Any input edge sets a sticky CHANGE bit; write 1 to clear.
 * Inputs sync to 0 in reset, so inputs high at reset release flag once.
 */
`timescale 1ns/10ps
`default_nettype none

module wb_gpio
	import soc_pkg::*;
(
	input  logic     clk_i,
	input  logic     rst_i,
	input  wb_req_t  req_i,
	output wb_rsp_t  rsp_o,
	input  gpio_in_t gpio_i,
	output data_t    gpio_o,
	output logic     irq_o
);

	logic       access;
	logic       wr;
	logic       ack;
	logic [1:0] reg_sel;
	gpio_in_t   sync1;
	gpio_in_t   sync2;
	gpio_in_t   last;
	gpio_in_t   change;
	gpio_in_t   clr_mask;
	data_t      out_reg;
	data_t      rdata;
	data_t      rdata_q;

	assign access   = req_i.cyc & req_i.stb & ~ack;
	assign wr       = access & req_i.we;
	assign reg_sel  = req_i.adr[3:2];
	assign clr_mask = (wr && reg_sel == GPIO_CHANGE) ? req_i.dat[11:0] : '0;

	// --------------------
	// Input side
	// --------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			sync1  <= '0;
			sync2  <= '0;
			last   <= '0;
			change <= '0;
		end else begin
			// Two-stage synchronizer
			sync1  <= gpio_i;
			sync2  <= sync1;
			last   <= sync2;
			// New edges win over a clear in the same cycle
			change <= (change & ~clr_mask) | (sync2 ^ last);
		end
	end

	// Output register, per byte lane
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			out_reg <= '0;
		end else if (wr && reg_sel == GPIO_OUT) begin
			for (int i = 0; i < 4; i++) begin
				if (req_i.sel[i]) begin
					out_reg[8*i +: 8] <= req_i.dat[8*i +: 8];
				end
			end
		end
	end

	// --------------------
	// Read path
	// --------------------
	always_comb begin
		case (reg_sel)
			GPIO_IN:     rdata = data_t'(sync2);
			GPIO_OUT:    rdata = out_reg;
			GPIO_CHANGE: rdata = data_t'(change);
			default:     rdata = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack <= 1'b0;
		end else begin
			ack <= access;
		end
	end

	always_ff @(posedge clk_i) begin
		if (access) begin
			rdata_q <= rdata;
		end
	end

	assign rsp_o.dat = rdata_q;
	assign rsp_o.ack = ack;
	assign gpio_o    = out_reg;
	assign irq_o     = |change;

endmodule

`default_nettype wire

/* rtl/sevenseg_scan.sv */
/*
 * Four-digit hex scanner for a common-anode display.
 * Shows value_i[15:0]; digit k is nibble k, anode k low.
 */
`timescale 1ns/10ps
`default_nettype none

module sevenseg_scan
	import soc_pkg::*;
(
	input  logic  clk_i,
	input  logic  rst_i,
	input  data_t value_i,
	output seg_t  seg_o,
	output an_t   an_o
);

	logic [SCAN_DIV_W-1:0] div;
	logic [1:0]            digit;
	logic [3:0]            nibble;

	// Dwell divider and digit index
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			div   <= '0;
			digit <= '0;
		end else begin
			div <= div + 1'b1;
			if (&div) begin
				digit <= digit + 1'b1;
			end
		end
	end

	assign nibble = value_i[4*digit +: 4];
	assign an_o   = ~(an_t'(1) << digit);

	// Hex decode, g..a order, low lights the segment
	always_comb begin
		case (nibble)
			4'h0: seg_o = 7'b1000000;
			4'h1: seg_o = 7'b1111001;
			4'h2: seg_o = 7'b0100100;
			4'h3: seg_o = 7'b0110000;
			4'h4: seg_o = 7'b0011001;
			4'h5: seg_o = 7'b0010010;
			4'h6: seg_o = 7'b0000010;
			4'h7: seg_o = 7'b1111000;
			4'h8: seg_o = 7'b0000000;
			4'h9: seg_o = 7'b0010000;
			4'hA: seg_o = 7'b0001000;
			4'hB: seg_o = 7'b0000011;
			4'hC: seg_o = 7'b1000110;
			4'hD: seg_o = 7'b0100001;
			4'hE: seg_o = 7'b0000110;
			default: seg_o = 7'b0001110;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/soc_top.sv */
/*
 * Board top: one external Wishbone master, BRAM, timer, GPIO, display.
 * Interrupts leave active high, bit 0 timer and bit 1 GPIO.
 * GPIO inputs are {sw, btn}; LEDs show GPIO OUT[7:0].
 */
`timescale 1ns/10ps
`default_nettype none

module soc_top
	import soc_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_i,
	// Bus master port
	input  wb_req_t    wb_req_i,
	output wb_rsp_t    wb_rsp_o,
	// Board I/O
	input  logic [3:0] btn_i,
	input  logic [7:0] sw_i,
	output logic [7:0] led_o,
	output seg_t       seg_o,
	output an_t        an_o,
	output irq_vec_t   irq_o
);

	wb_req_t  bram_req;
	wb_req_t  tmr_req;
	wb_req_t  gpio_req;
	wb_rsp_t  bram_rsp;
	wb_rsp_t  tmr_rsp;
	wb_rsp_t  gpio_rsp;
	gpio_in_t gpio_in;
	data_t    gpio_out;
	logic     tmr_irq;
	logic     gpio_irq;

	// --------------------
	// Interconnect
	// --------------------
	wb_decoder decoder0 (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.m_req_i    (wb_req_i),
		.m_rsp_o    (wb_rsp_o),
		.bram_req_o (bram_req),
		.tmr_req_o  (tmr_req),
		.gpio_req_o (gpio_req),
		.bram_rsp_i (bram_rsp),
		.tmr_rsp_i  (tmr_rsp),
		.gpio_rsp_i (gpio_rsp)
	);

	// --------------------
	// Slaves
	// --------------------
	wb_bram bram0 (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.req_i (bram_req),
		.rsp_o (bram_rsp)
	);

	wb_timer timer0 (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.req_i (tmr_req),
		.rsp_o (tmr_rsp),
		.irq_o (tmr_irq)
	);

	wb_gpio gpio0 (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.req_i  (gpio_req),
		.rsp_o  (gpio_rsp),
		.gpio_i (gpio_in),
		.gpio_o (gpio_out),
		.irq_o  (gpio_irq)
	);

	// Display shows GPIO OUT[15:0]
	sevenseg_scan sevenseg0 (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.value_i (gpio_out),
		.seg_o   (seg_o),
		.an_o    (an_o)
	);

	assign gpio_in = {sw_i, btn_i};
	assign led_o   = gpio_out[7:0];
	assign irq_o   = {gpio_irq, tmr_irq};

endmodule

`default_nettype wire

/* verif/tb_soc.sv */
/*
 * Directed testbench for soc_top, acting as the only Wishbone master.
 * Requests change on the falling edge, responses are sampled there too.
 * BRAM model covers only the words written here.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_soc
	import soc_pkg::*;
();

	localparam logic [31:0] LFSR_SEED   = 32'hd9db_65c0;
	// Right-shifting form of x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;
	localparam int          CYCLE_LIMIT = 2000;
	localparam addr_t       UNMAPPED    = 32'hF000_0000;

	logic        clk;
	logic        rst;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	logic [3:0]  btn;
	logic [7:0]  sw;
	logic [7:0]  led;
	seg_t        seg;
	an_t         an;
	irq_vec_t    irq;
	int          errors = 0;
	int          cycles = 0;
	logic [31:0] lfsr_state;
	seg_t        seg_table [0:15];

	soc_top dut (
		.clk_i    (clk),
		.rst_i    (rst),
		.wb_req_i (wb_req),
		.wb_rsp_o (wb_rsp),
		.btn_i    (btn),
		.sw_i     (sw),
		.led_o    (led),
		.seg_o    (seg),
		.an_o     (an),
		.irq_o    (irq)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped at the cycle limit of %0d before the tests finished", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// --------------------
	// Helpers
	// --------------------
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		v = '0;
		// One LFSR step per bit taken
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic data_t merge_bytes(input data_t old, input data_t nw, input sel_t sel);
		data_t r;
		r = old;
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				r[8*i +: 8] = nw[8*i +: 8];
			end
		end
		return r;
	endfunction

	// Region in 31..17 and word offset in 3..2
	function automatic addr_t reg_addr(input logic [REGION_MSB:REGION_LSB] region,
			input logic [1:0] off);
		return {region, 13'h0, off, 2'b00};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		$display("error: %s expected %h got %h", name, exp, got);
		errors++;
	endtask

	// Active low with bit 6 as g and bit 0 as a
	task automatic load_seg_table();
		seg_table[0]  = 7'h40;
		seg_table[1]  = 7'h79;
		seg_table[2]  = 7'h24;
		seg_table[3]  = 7'h30;
		seg_table[4]  = 7'h19;
		seg_table[5]  = 7'h12;
		seg_table[6]  = 7'h02;
		seg_table[7]  = 7'h78;
		seg_table[8]  = 7'h00;
		seg_table[9]  = 7'h10;
		seg_table[10] = 7'h08;
		seg_table[11] = 7'h03;
		seg_table[12] = 7'h46;
		seg_table[13] = 7'h21;
		seg_table[14] = 7'h06;
		seg_table[15] = 7'h0E;
	endtask

	// --------------------
	// Bus tasks
	// --------------------
	// Entered and left on a falling edge
	task automatic bus_cycle(input logic we, input addr_t adr, input data_t dat,
			input sel_t sel, output data_t rdat);
		int waited;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = dat;
		wb_req.sel = sel;
		@(negedge clk);
		waited = 1;
		while (wb_rsp.ack !== 1'b1 && waited < 4) begin
			@(negedge clk);
			waited++;
		end
		if (wb_rsp.ack !== 1'b1) begin
			$display("error: no ack within 4 cycles for the access to %h", adr);
			errors++;
		end
		rdat   = wb_rsp.dat;
		wb_req = '0;
	endtask

	task automatic wb_write(input addr_t adr, input data_t dat, input sel_t sel);
		data_t unused;
		bus_cycle(1'b1, adr, dat, sel, unused);
	endtask

	task automatic wb_read(input addr_t adr, output data_t dat);
		bus_cycle(1'b0, adr, '0, 4'hF, dat);
	endtask

	task automatic wait_for_irq(input int line, input int limit, input string what);
		int waited;
		waited = 0;
		while (irq[line] !== 1'b1 && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (irq[line] !== 1'b1) begin
			$display("error: %s did not arrive within %0d cycles", what, limit);
			errors++;
		end
	endtask

	// --------------------
	// Directed tests
	// --------------------
	task automatic check_reset_state();
		if (wb_rsp.ack !== 1'b0)
			report_mismatch("wb_rsp_o.ack", 0, wb_rsp.ack);
		if (irq !== 2'b00)
			report_mismatch("irq_o", 0, irq);
		if (led !== 8'h00)
			report_mismatch("led_o", 0, led);
		if (an !== 4'b1110)
			report_mismatch("an_o", 4'b1110, an);
		if (seg !== seg_table[0])
			report_mismatch("seg_o", seg_table[0], seg);
	endtask

	task automatic test_bram();
		logic [BRAM_AW-1:0] idx [16];
		data_t              model [0:(2**BRAM_AW)-1];
		data_t              wd;
		data_t              rd;
		sel_t               sel;
		int                 k;
		for (int i = 0; i < 16; i++) begin
			idx[i]        = next_bits(BRAM_AW);
			wd            = next_bits(32);
			model[idx[i]] = wd;
			wb_write(addr_t'({idx[i], 2'b00}), wd, 4'hF);
		end
		// One lane of one word rewritten
		k   = next_bits(4);
		sel = sel_t'(1) << next_bits(2);
		wd  = next_bits(32);
		model[idx[k]] = merge_bytes(model[idx[k]], wd, sel);
		wb_write(addr_t'({idx[k], 2'b00}), wd, sel);
		for (int i = 0; i < 16; i++) begin
			wb_read(addr_t'({idx[i], 2'b00}), rd);
			if (rd !== model[idx[i]])
				report_mismatch("wb_rsp_o.dat", model[idx[i]], rd);
		end
	endtask

	task automatic test_unmapped();
		data_t rd;
		wb_write(32'h0, 32'h1234_5678, 4'hF);
		wb_read(UNMAPPED, rd);
		if (rd !== 32'h0)
			report_mismatch("wb_rsp_o.dat", 0, rd);
		// Low bits alias RAM word 0 and timer CTRL if misrouted
		wb_write(UNMAPPED, 32'hFFFF_FFFF, 4'hF);
		// Next word aliases timer COMPARE and GPIO OUT
		wb_write(UNMAPPED + 32'h4, 32'hFFFF_FFFF, 4'hF);
		wb_read(32'h0, rd);
		if (rd !== 32'h1234_5678)
			report_mismatch("wb_rsp_o.dat", 32'h1234_5678, rd);
		wb_read(reg_addr(TIMER_REGION, TMR_CTRL), rd);
		if (rd !== 32'h0)
			report_mismatch("timer CTRL", 0, rd);
		wb_read(reg_addr(TIMER_REGION, TMR_COMPARE), rd);
		if (rd !== 32'h0)
			report_mismatch("timer COMPARE", 0, rd);
		wb_read(reg_addr(GPIO_REGION, GPIO_OUT), rd);
		if (rd !== 32'h0)
			report_mismatch("gpio OUT", 0, rd);
	endtask

	task automatic test_timer_oneshot();
		data_t rd;
		wb_write(reg_addr(TIMER_REGION, TMR_COMPARE), 32'd20, 4'hF);
		wb_write(reg_addr(TIMER_REGION, TMR_CTRL), 32'h1 << CTRL_EN, 4'hF);
		wait_for_irq(0, 40, "timer one-shot interrupt");
		wb_read(reg_addr(TIMER_REGION, TMR_COUNTER), rd);
		if (rd !== 32'd20)
			report_mismatch("timer COUNTER", 20, rd);
		// EN dropped and flag set
		wb_read(reg_addr(TIMER_REGION, TMR_CTRL), rd);
		if (rd !== (32'h1 << CTRL_IRQ))
			report_mismatch("timer CTRL", 32'h1 << CTRL_IRQ, rd);
		wb_write(reg_addr(TIMER_REGION, TMR_CTRL), 32'h1 << CTRL_IRQ, 4'hF);
		if (irq[0] !== 1'b0)
			report_mismatch("irq_o[0]", 0, irq[0]);
	endtask

	task automatic test_timer_reload();
		data_t ctrl_run;
		data_t rd;
		ctrl_run = (32'h1 << CTRL_EN) | (32'h1 << CTRL_AR);
		wb_write(reg_addr(TIMER_REGION, TMR_COUNTER), 32'd0, 4'hF);
		wb_write(reg_addr(TIMER_REGION, TMR_COMPARE), 32'd10, 4'hF);
		wb_write(reg_addr(TIMER_REGION, TMR_CTRL), ctrl_run, 4'hF);
		wait_for_irq(0, 30, "first timer reload interrupt");
		// Clear while keeping EN and AR
		wb_write(reg_addr(TIMER_REGION, TMR_CTRL), ctrl_run | (32'h1 << CTRL_IRQ), 4'hF);
		if (irq[0] !== 1'b0)
			report_mismatch("irq_o[0]", 0, irq[0]);
		wait_for_irq(0, 30, "second timer reload interrupt");
		wb_read(reg_addr(TIMER_REGION, TMR_CTRL), rd);
		if (rd[CTRL_EN] !== 1'b1)
			report_mismatch("timer CTRL.EN", 1, rd[CTRL_EN]);
		// Stop the timer
		wb_write(reg_addr(TIMER_REGION, TMR_CTRL), 32'h1 << CTRL_IRQ, 4'hF);
	endtask

	task automatic test_gpio_out();
		data_t      model;
		data_t      wd;
		data_t      rd;
		seg_t       exp_seg;
		int         lows;
		int         digit;
		logic [3:0] seen;
		model = 32'h0000_3A5C;
		wb_write(reg_addr(GPIO_REGION, GPIO_OUT), model, 4'hF);
		if (led !== model[7:0])
			report_mismatch("led_o", model[7:0], led);
		// Byte lane 1 only
		wd    = next_bits(32);
		model = merge_bytes(model, wd, 4'b0010);
		wb_write(reg_addr(GPIO_REGION, GPIO_OUT), wd, 4'b0010);
		if (led !== model[7:0])
			report_mismatch("led_o", model[7:0], led);
		wb_read(reg_addr(GPIO_REGION, GPIO_OUT), rd);
		if (rd !== model)
			report_mismatch("gpio OUT", model, rd);
		// Four dwell periods cover every digit
		seen = '0;
		repeat (64) begin
			@(negedge clk);
			lows  = 0;
			digit = 0;
			for (int k = 0; k < 4; k++) begin
				if (an[k] === 1'b0) begin
					lows++;
					digit = k;
				end
			end
			if (lows != 1) begin
				$display("error: an_o = %h does not select exactly one digit", an);
				errors++;
			end else begin
				seen[digit] = 1'b1;
				exp_seg     = seg_table[model[4*digit +: 4]];
				if (seg !== exp_seg)
					report_mismatch("seg_o", exp_seg, seg);
			end
		end
		if (seen !== 4'hF) begin
			$display("error: the display scanned only digits %b of all four", seen);
			errors++;
		end
	endtask

	task automatic test_gpio_in();
		gpio_in_t exp_in;
		data_t    rd;
		btn[2] = 1'b1;
		sw[5]  = 1'b1;
		// Switches above buttons
		exp_in = {sw, btn};
		wait_for_irq(1, 5, "GPIO change interrupt");
		wb_read(reg_addr(GPIO_REGION, GPIO_IN), rd);
		if (rd !== data_t'(exp_in))
			report_mismatch("gpio IN", data_t'(exp_in), rd);
		wb_read(reg_addr(GPIO_REGION, GPIO_CHANGE), rd);
		if (rd !== 32'h0000_0204)
			report_mismatch("gpio CHANGE", 32'h0000_0204, rd);
		wb_write(reg_addr(GPIO_REGION, GPIO_CHANGE), 32'h0000_0204, 4'hF);
		if (irq[1] !== 1'b0)
			report_mismatch("irq_o[1]", 0, irq[1]);
		wb_read(reg_addr(GPIO_REGION, GPIO_CHANGE), rd);
		if (rd !== 32'h0)
			report_mismatch("gpio CHANGE", 0, rd);
	endtask

	// --------------------
	// Sequence
	// --------------------
	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		wb_req     = '0;
		btn        = '0;
		sw         = '0;
		lfsr_state = LFSR_SEED;
		load_seg_table();
		repeat (2) @(negedge clk);
		check_reset_state();
		rst = 1'b0;
		test_bram();
		test_unmapped();
		test_timer_oneshot();
		test_timer_reload();
		test_gpio_out();
		test_gpio_in();
		$display("checks failed: %0d", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
rtl/soc_pkg.sv
rtl/wb_decoder.sv
rtl/wb_bram.sv
rtl/wb_timer.sv
rtl/wb_gpio.sv
rtl/sevenseg_scan.sv
rtl/soc_top.sv
verif/tb_soc.sv

/* Bender.yml */
package:
  name: soc_wb

sources:
  - rtl/soc_pkg.sv
  - rtl/wb_decoder.sv
  - rtl/wb_bram.sv
  - rtl/wb_timer.sv
  - rtl/wb_gpio.sv
  - rtl/sevenseg_scan.sv
  - rtl/soc_top.sv
  - target: simulation
    files:
      - verif/tb_soc.sv
